// ==== tb.f ====
logic/mhq_cfg_pkg.sv
logic/mhq_if_pkg.sv
logic/mhq_lookup.sv
logic/mhq_execute.sv
logic/ccu_line_fetch.sv
logic/mhq_top.sv
test/mhq_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MHQ testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mhq_tb -f tb.f -o mhq_sim

./obj_dir/mhq_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// ==== test/mhq_stim.txt ====
# R is_store addr wr_data byte_sel gap   (hex, gap is idle cycles before the request, decimal)
# F tag dirty addr data                  (hex, expected fills in fill order)
# Single load miss
R 0 00001004 00000000 0 0
F 0 0 00001000 0f0e0d0c0b0a09080706050403020100
# Store miss, bytes 0 and 2 at offset 8
R 1 00002008 aabbccdd 5 12
F 1 1 00002000 0f0e0d0c0bbb09dd0706050403020100
# Two stores and a load to one pending line, second store wins on overlap
R 1 00003034 11223344 f 12
R 1 00003036 55667788 3 0
R 0 00003030 00000000 0 0
F 2 1 00003030 3f3e3d3c3b3a39387788334433323130
# Store that runs past the line end
R 1 0000410e deadbeef f 12
F 3 1 00004100 beef0d0c0b0a09080706050403020100
# Five back-to-back misses, the fifth waits for a free entry
R 0 00005038 00000000 0 12
R 0 00006014 00000000 0 0
R 0 0000702c 00000000 0 0
R 0 00008000 00000000 0 0
R 0 0000903c 00000000 0 0
F 0 0 00005030 3f3e3d3c3b3a39383736353433323130
F 1 0 00006010 1f1e1d1c1b1a19181716151413121110
F 2 0 00007020 2f2e2d2c2b2a29282726252423222120
F 3 0 00008000 0f0e0d0c0b0a09080706050403020100
F 0 0 00009030 3f3e3d3c3b3a39383736353433323130

// ==== test/mhq_tb.sv ====
// ####################################################################
// MHQ testbench, file driven requests with checked fills
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mhq_tb
    import mhq_cfg_pkg::*;
    import mhq_if_pkg::*;
();

    logic      clk;
    logic      n_rst;
    logic      i_req_valid;
    mhq_req_t  i_req;
    logic      o_req_ready;
    logic      o_fill_valid;
    mhq_fill_t o_fill;

    mhq_req_t  req_q [$];
    int        gap_q [$];
    mhq_fill_t exp_q [$];
    int        fill_idx    = 0;
    int        cycle_cnt   = 0;
    int        cycle_limit = 1000;
    logic      saw_stall   = 1'b0;

    mhq_top mhq_top_inst (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_ready  (o_req_ready),
        .o_fill_valid (o_fill_valid),
        .o_fill       (o_fill)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_error(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    // R and F records go to separate queues, comment lines start with #
    task automatic load_stimulus();
        int           fd;
        int           ch;
        int           n;
        int           gap;
        logic [127:0] f0, f1, f2, f3;
        mhq_req_t     req;
        mhq_fill_t    fill;
        fd = $fopen("test/mhq_stim.txt", "r");
        if (fd == 0) begin
            report_error("cannot open stimulus file test/mhq_stim.txt");
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == "#") begin
                while (ch != -1 && ch != "\n") begin
                    ch = $fgetc(fd);
                end
            end else if (ch == "R") begin
                n = $fscanf(fd, "%h %h %h %h %d", f0, f1, f2, f3, gap);
                if (n != 5) begin
                    report_error("malformed R record in stimulus file");
                end
                req.is_store = f0[0];
                req.addr     = f1[ADDR_W-1:0];
                req.wr_data  = f2[DATA_W-1:0];
                req.byte_sel = f3[WORD_BYTES-1:0];
                req_q.push_back(req);
                gap_q.push_back(gap);
            end else if (ch == "F") begin
                n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                if (n != 4) begin
                    report_error("malformed F record in stimulus file");
                end
                fill.tag   = f0[MHQ_IDX_W-1:0];
                fill.dirty = f1[0];
                fill.addr  = f2[ADDR_W-1:0];
                fill.data  = f3[LINE_W-1:0];
                exp_q.push_back(fill);
            end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                report_error("unexpected character in stimulus file");
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = 40 * (req_q.size() + exp_q.size()) + 50;
    endtask

    // Ready is read after the falling edge so it is settled before the rising edge
    task automatic send_request(input mhq_req_t req, input int gap);
        logic acc;
        repeat (gap) begin
            @(negedge clk);
            i_req_valid = 1'b0;
        end
        @(negedge clk);
        i_req_valid = 1'b1;
        i_req       = req;
        acc         = 1'b0;
        while (!acc) begin
            #1;
            acc = o_req_ready;
            if (!acc) begin
                saw_stall = 1'b1;
            end
            @(posedge clk);
            if (!acc) begin
                @(negedge clk);
            end
        end
    endtask

    // Fill is registered, so it is steady at the falling edge
    always @(negedge clk) begin
        mhq_fill_t exp_fill;
        if (n_rst && o_fill_valid) begin
            assert (fill_idx < exp_q.size())
                else report_error("a fill arrived with no expected fill left");
            exp_fill = exp_q[fill_idx];
            assert (o_fill.tag == exp_fill.tag)
                else report_error($sformatf("FAIL at time %0t: o_fill.tag got %h expected %h",
                    $time, o_fill.tag, exp_fill.tag));
            assert (o_fill.dirty == exp_fill.dirty)
                else report_error($sformatf("FAIL at time %0t: o_fill.dirty got %b expected %b",
                    $time, o_fill.dirty, exp_fill.dirty));
            assert (o_fill.addr == exp_fill.addr)
                else report_error($sformatf("FAIL at time %0t: o_fill.addr got %h expected %h",
                    $time, o_fill.addr, exp_fill.addr));
            assert (o_fill.data == exp_fill.data)
                else report_error($sformatf("FAIL at time %0t: o_fill.data got %h expected %h",
                    $time, o_fill.data, exp_fill.data));
            fill_idx++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            report_error($sformatf("timeout after %0d cycles with %0d of %0d fills seen",
                cycle_cnt, fill_idx, exp_q.size()));
        end
    end

    initial begin
        n_rst       = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        load_stimulus();
        repeat (2) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // Idle queue after reset
        repeat (10) begin
            @(negedge clk);
            assert (o_req_ready)
                else report_error($sformatf("FAIL at time %0t: o_req_ready got %b expected 1",
                    $time, o_req_ready));
            assert (!o_fill_valid)
                else report_error($sformatf("FAIL at time %0t: o_fill_valid got %b expected 0",
                    $time, o_fill_valid));
        end

        for (int i = 0; i < req_q.size(); i++) begin
            send_request(req_q[i], gap_q[i]);
        end
        @(negedge clk);
        i_req_valid = 1'b0;

        wait (fill_idx == exp_q.size());
        // Any extra fill in this window is caught by the fill checker
        repeat (20) @(negedge clk);
        assert (saw_stall)
            else report_error("o_req_ready never dropped while the queue was full");

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/mhq_top.sv ====
// ####################################################################
// Miss handling queue top, lookup, execute and line fetch
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mhq_top
    import mhq_cfg_pkg::*;
    import mhq_if_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    input  logic      i_req_valid,
    input  mhq_req_t  i_req,
    output logic      o_req_ready,

    output logic      o_fill_valid,
    output mhq_fill_t o_fill
);

    logic [MHQ_DEPTH-1:0] entry_valid;
    line_addr_t           entry_addr [MHQ_DEPTH];
    mhq_ptr_t             head_next;
    mhq_ptr_t             tail_next;
    logic                 lu_en;
    mhq_lu_t              lu;
    logic                 ccu_en;
    line_addr_t           ccu_addr;
    logic                 ccu_done;
    line_data_t           ccu_data;

    mhq_lookup mhq_lookup_inst (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .i_entry_valid (entry_valid),
        .i_entry_addr  (entry_addr),
        .i_head_next   (head_next),
        .i_tail_next   (tail_next),
        .o_lu_en       (lu_en),
        .o_lu          (lu)
    );

    mhq_execute mhq_execute_inst (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_lu_en       (lu_en),
        .i_lu          (lu),
        .o_entry_valid (entry_valid),
        .o_entry_addr  (entry_addr),
        .o_head_next   (head_next),
        .o_tail_next   (tail_next),
        .o_ccu_en      (ccu_en),
        .o_ccu_addr    (ccu_addr),
        .i_ccu_done    (ccu_done),
        .i_ccu_data    (ccu_data),
        .o_fill_valid  (o_fill_valid),
        .o_fill        (o_fill)
    );

    ccu_line_fetch ccu_line_fetch_inst (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_ccu_en      (ccu_en),
        .i_ccu_addr    (ccu_addr),
        .o_ccu_done    (ccu_done),
        .o_ccu_data    (ccu_data)
    );

endmodule

`default_nettype wire

// ==== logic/ccu_line_fetch.sv ====
// ####################################################################
// Line fetch model with address dependent latency and rule data
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module ccu_line_fetch
    import mhq_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       n_rst,

    input  logic       i_ccu_en,
    input  line_addr_t i_ccu_addr,
    output logic       o_ccu_done,
    output line_data_t o_ccu_data
);

    // Wide enough for CCU_BASE_LAT plus the largest address term of 3
    localparam int CNT_W = $clog2(CCU_BASE_LAT + 4);

    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] lat_m1;
    logic             start;

    assign start  = i_ccu_en & ~busy_q;
    assign lat_m1 = CNT_W'(CCU_BASE_LAT - 1) + CNT_W'(i_ccu_addr[1:0]);

    assign o_ccu_done = busy_q & (cnt_q == '0);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= lat_m1;
        end else if (o_ccu_done) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    // Byte k of line L reads as L * LINE_BYTES + k, mod 256
    always_comb begin
        for (int k = 0; k < LINE_BYTES; k++) begin
            o_ccu_data[k*8 +: 8] = 8'({i_ccu_addr, OFFSET_W'(k)});
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!n_rst)
        busy_q |-> (i_ccu_en && $stable(i_ccu_addr)))
        else $error("line fetch request changed while pending");

endmodule

`default_nettype wire

// ==== logic/mhq_execute.sv ====
// ####################################################################
// MHQ execute stage, entry storage, store merge and fill assembly
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mhq_execute
    import mhq_cfg_pkg::*;
    import mhq_if_pkg::*;
(
    input  logic                 clk,
    input  logic                 n_rst,

    input  logic                 i_lu_en,
    input  mhq_lu_t              i_lu,

    // Unregistered feedback to lookup
    output logic [MHQ_DEPTH-1:0] o_entry_valid,
    output line_addr_t           o_entry_addr [MHQ_DEPTH],
    output mhq_ptr_t             o_head_next,
    output mhq_ptr_t             o_tail_next,

    output logic                 o_ccu_en,
    output line_addr_t           o_ccu_addr,
    input  logic                 i_ccu_done,
    input  line_data_t           i_ccu_data,

    output logic                 o_fill_valid,
    output mhq_fill_t            o_fill
);

    logic [MHQ_DEPTH-1:0]  valid_q;
    logic [MHQ_DEPTH-1:0]  valid_next;
    logic                  dirty_q [MHQ_DEPTH];
    line_addr_t            addr_q  [MHQ_DEPTH];
    line_data_t            data_q  [MHQ_DEPTH];
    logic [LINE_BYTES-1:0] upd_q   [MHQ_DEPTH];

    mhq_ptr_t              head_q;
    mhq_ptr_t              tail_q;
    mhq_ptr_t              head_next;
    mhq_ptr_t              tail_next;
    mhq_ptr_t              count_q;
    mhq_idx_t              head_idx;

    logic                  alloc;
    logic                  ex_dirty;
    line_data_t            ex_data;
    logic [LINE_BYTES-1:0] ex_upd;
    logic                  fill_merge;
    line_data_t            fill_data;

    assign alloc     = i_lu_en & i_lu.alloc;
    assign head_idx  = head_q[MHQ_IDX_W-1:0];
    assign count_q   = tail_q - head_q;
    assign head_next = i_ccu_done ? head_q + 1'b1 : head_q;
    assign tail_next = alloc ? tail_q + 1'b1 : tail_q;

    assign o_head_next   = head_next;
    assign o_tail_next   = tail_next;
    assign o_entry_valid = valid_q;
    assign o_entry_addr  = addr_q;

    // Head entry is always the one being fetched
    assign o_ccu_en   = valid_q[head_idx];
    assign o_ccu_addr = addr_q[head_idx];

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            valid_next[i] = (valid_q[i] | (alloc & (i_lu.tag == mhq_idx_t'(i))))
                          & ~(i_ccu_done & (head_idx == mhq_idx_t'(i)));
        end
    end

    // Store bytes land at offset + j, anything past the line end is dropped
    always_comb begin
        logic [OFFSET_W:0] pos;
        ex_dirty = i_lu.we | (i_lu.merge & dirty_q[i_lu.tag]);
        ex_data  = data_q[i_lu.tag];
        ex_upd   = i_lu.alloc ? '0 : upd_q[i_lu.tag];
        for (int j = 0; j < WORD_BYTES; j++) begin
            pos = {1'b0, i_lu.offset} + (OFFSET_W+1)'(j);
            if (i_lu.we && i_lu.byte_sel[j] && (pos < (OFFSET_W+1)'(LINE_BYTES))) begin
                ex_data[pos[OFFSET_W-1:0]*8 +: 8] = i_lu.wr_data[j*8 +: 8];
                ex_upd[pos[OFFSET_W-1:0]]         = 1'b1;
            end
        end
    end

    // Byte priority: enqueuing store, then earlier stores, then memory
    always_comb begin
        fill_merge = i_lu_en & i_lu.we & (i_lu.addr == addr_q[head_idx]);
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (fill_merge && ex_upd[i]) begin
                fill_data[i*8 +: 8] = ex_data[i*8 +: 8];
            end else if (upd_q[head_idx][i]) begin
                fill_data[i*8 +: 8] = data_q[head_idx][i*8 +: 8];
            end else begin
                fill_data[i*8 +: 8] = i_ccu_data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_next;
        end
    end

    // Allocate or merge into the tagged entry
    always_ff @(posedge clk) begin
        if (i_lu_en) begin
            dirty_q[i_lu.tag] <= ex_dirty;
            addr_q[i_lu.tag]  <= i_lu.addr;
            data_q[i_lu.tag]  <= ex_data;
            upd_q[i_lu.tag]   <= ex_upd;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_fill_valid <= 1'b0;
        end else begin
            o_fill_valid <= i_ccu_done;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ccu_done) begin
            o_fill.tag   <= head_idx;
            o_fill.dirty <= dirty_q[head_idx] | fill_merge;
            o_fill.addr  <= {addr_q[head_idx], {OFFSET_W{1'b0}}};
            o_fill.data  <= fill_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_next;
            tail_q <= tail_next;
        end
    end

    // Lookup must hold back new lines once every entry is taken
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        alloc |-> (count_q != mhq_ptr_t'(MHQ_DEPTH)))
        else $error("MHQ allocation while full");

    a_done_on_valid: assert property (@(posedge clk) disable iff (!n_rst)
        i_ccu_done |-> valid_q[head_idx])
        else $error("line fetch done with no valid head entry");

endmodule

`default_nettype wire

// ==== logic/mhq_lookup.sv ====
// ####################################################################
// MHQ lookup stage, line match, tag choice and back-pressure
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mhq_lookup
    import mhq_cfg_pkg::*;
    import mhq_if_pkg::*;
(
    input  logic                 clk,
    input  logic                 n_rst,

    input  logic                 i_req_valid,
    input  mhq_req_t             i_req,
    output logic                 o_req_ready,

    // Queue state fed back from execute
    input  logic [MHQ_DEPTH-1:0] i_entry_valid,
    input  line_addr_t           i_entry_addr [MHQ_DEPTH],
    input  mhq_ptr_t             i_head_next,
    input  mhq_ptr_t             i_tail_next,

    output logic                 o_lu_en,
    output mhq_lu_t              o_lu
);

    line_addr_t           req_line;
    mhq_ptr_t             count_next;
    logic [MHQ_DEPTH-1:0] in_range;
    logic [MHQ_DEPTH-1:0] hit_vec;
    logic                 byp_hit;
    logic                 hit;
    logic                 full;
    logic                 accept;
    mhq_idx_t             hit_tag;
    mhq_idx_t             tag;

    assign req_line   = i_req.addr[ADDR_W-1:OFFSET_W];
    assign count_next = i_tail_next - i_head_next;
    assign full       = (count_next == mhq_ptr_t'(MHQ_DEPTH));

    // An entry only counts if it is still occupied after this edge
    always_comb begin
        mhq_idx_t rel;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            rel         = mhq_idx_t'(i) - i_head_next[MHQ_IDX_W-1:0];
            in_range[i] = ({1'b0, rel} < count_next);
            hit_vec[i]  = i_entry_valid[i] & in_range[i] & (i_entry_addr[i] == req_line);
        end
    end

    // Entry being written by execute right now is not visible yet
    assign byp_hit = o_lu_en & o_lu.alloc & (o_lu.addr == req_line);
    assign hit     = (|hit_vec) | byp_hit;

    always_comb begin
        hit_tag = o_lu.tag;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (hit_vec[i]) begin
                hit_tag = mhq_idx_t'(i);
            end
        end
    end

    assign tag         = hit ? hit_tag : i_tail_next[MHQ_IDX_W-1:0];
    assign o_req_ready = hit | ~full;
    assign accept      = i_req_valid & o_req_ready;

    // Loads to a pending line need no work downstream
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_lu_en <= 1'b0;
        end else begin
            o_lu_en <= accept & (~hit | i_req.is_store);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_lu.alloc    <= ~hit;
            o_lu.merge    <= hit;
            o_lu.we       <= i_req.is_store;
            o_lu.tag      <= tag;
            o_lu.addr     <= req_line;
            o_lu.offset   <= i_req.addr[OFFSET_W-1:0];
            o_lu.wr_data  <= i_req.wr_data;
            o_lu.byte_sel <= i_req.byte_sel;
        end
    end

    // A line lives in at most one entry, including the one in flight
    a_single_match: assert property (@(posedge clk) disable iff (!n_rst)
        i_req_valid |-> $onehot0({hit_vec, byp_hit}))
        else $error("multiple MHQ entries match line %h", req_line);

endmodule

`default_nettype wire

// ==== logic/mhq_if_pkg.sv ====
// ####################################################################
// Miss handling queue request, lookup result and fill records
// ####################################################################

`default_nettype none

package mhq_if_pkg;
    import mhq_cfg_pkg::*;

    // Miss request from the cache
    typedef struct packed {
        logic                  is_store;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_W-1:0]     wr_data;
        logic [WORD_BYTES-1:0] byte_sel;
    } mhq_req_t;

    // Lookup stage result handed to execute
    typedef struct packed {
        logic                  alloc;
        logic                  merge;
        logic                  we;
        mhq_idx_t              tag;
        line_addr_t            addr;
        logic [OFFSET_W-1:0]   offset;
        logic [DATA_W-1:0]     wr_data;
        logic [WORD_BYTES-1:0] byte_sel;
    } mhq_lu_t;

    // Line fill returned to the cache
    typedef struct packed {
        mhq_idx_t              tag;
        logic                  dirty;
        logic [ADDR_W-1:0]     addr;
        line_data_t            data;
    } mhq_fill_t;

endpackage

`default_nettype wire

// ==== logic/mhq_cfg_pkg.sv ====
// ####################################################################
// Miss handling queue sizing, index and address types
// ####################################################################

`default_nettype none

package mhq_cfg_pkg;

    // Queue sizing
    localparam int MHQ_DEPTH    = 4;
    localparam int MHQ_IDX_W    = $clog2(MHQ_DEPTH);

    // Address and data geometry
    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 32;
    localparam int WORD_BYTES   = DATA_W / 8;
    localparam int LINE_BYTES   = 16;
    localparam int LINE_W       = LINE_BYTES * 8;
    localparam int OFFSET_W     = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_W  = ADDR_W - OFFSET_W;

    // Shortest line fetch in cycles
    localparam int CCU_BASE_LAT = 2;

    typedef logic [MHQ_IDX_W-1:0]   mhq_idx_t;
    // Extra top bit tells full from empty
    typedef logic [MHQ_IDX_W:0]     mhq_ptr_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [LINE_W-1:0]      line_data_t;

endpackage

`default_nettype wire
